//--- hw/fizzle_pkg.sv
// ########################################
// shared sizes, raster geometry, fade control and bus structs
// imported by every block of the fizzle framebuffer
// ########################################
package fizzle_pkg;

    // screen coordinates and framebuffer shape
    localparam int cordw     = 10;                      // signed coordinate width
    localparam int fb_width  = 16;
    localparam int fb_height = 12;
    localparam int fb_scale  = 2;                       // each fb pixel is 2x2 on screen
    localparam int fb_pixels = fb_width * fb_height;    // 192 words
    localparam int fb_addrw  = 8;
    localparam int fb_xw     = $clog2(fb_width);        // column within a row
    localparam int fb_yw     = $clog2(fb_height);       // row number

    // colour
    localparam int cidxw = 4;           // palette index
    localparam int chanw = 4;           // bits per channel before widening
    localparam int colrw = 3 * chanw;   // one palette entry

    // raster, tiny blanking, no sync modelled
    localparam int h_active = 32;
    localparam int h_total  = 40;
    localparam int v_active = 24;
    localparam int v_total  = 28;

    // fade control
    localparam int fade_wait = 3;       // frames shown untouched
    localparam int fade_rate = 20;      // cycles per LFSR step
    localparam logic [cidxw-1:0]    fade_cidx = 4'd7;
    localparam logic [fb_addrw-1:0] lfsr_seed = 8'h01;
    localparam logic [fb_addrw-1:0] lfsr_taps = 8'hB8;  // x^8+x^6+x^5+x^4+1, maximal

    // memory init files, looked up in the run directory
    localparam string image_file   = "image.mem";
    localparam string palette_file = "palette.mem";

    typedef struct packed {
        logic signed [cordw-1:0] sx;
        logic signed [cordw-1:0] sy;
        logic                    de;     // inside active area
        logic                    frame;  // first cycle of frame, (0,0)
        logic                    line;   // first cycle of each line
    } raster_t;

    typedef struct packed {
        logic                we;
        logic [fb_addrw-1:0] addr;
        logic [cidxw-1:0]    cidx;
    } fb_wr_t;

    typedef struct packed {
        logic [chanw-1:0] r;
        logic [chanw-1:0] g;
        logic [chanw-1:0] b;
    } rgb12_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb24_t;

endpackage

//--- hw/display_timing.sv
// ########################################
// raster counters, one position per clock
// gives coordinates, data enable and frame/line flags
// ########################################
`timescale 1ns/1ps

module display_timing (
    input  logic                clk_sys,
    input  logic                rst,
    output fizzle_pkg::raster_t raster
);
    import fizzle_pkg::*;

    logic [cordw-1:0] hc;  // horizontal count
    logic [cordw-1:0] vc;  // vertical count
    logic h_last;
    logic v_last;

    always_comb begin
        h_last = (hc == cordw'(h_total - 1));
        v_last = (vc == cordw'(v_total - 1));
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hc <= '0;
            vc <= '0;
        end else begin
            hc <= h_last ? '0 : hc + 1'b1;
            if (h_last) begin
                vc <= v_last ? '0 : vc + 1'b1;  // wrap to top of next frame
            end
        end
    end

    // counters never go negative, sign bit stays clear
    always_comb begin
        raster.sx    = signed'(hc);
        raster.sy    = signed'(vc);
        raster.de    = (hc < cordw'(h_active)) && (vc < cordw'(v_active));
        raster.line  = (hc == '0);
        raster.frame = (hc == '0) && (vc == '0);
    end

    // frame start is also a line start
    a_frame_line: assert property (@(posedge clk_sys) disable iff (rst)
        raster.frame |-> raster.line);

    // line flags come exactly one line apart
    a_line_period: assert property (@(posedge clk_sys) disable iff (rst)
        raster.line |-> ##h_total raster.line);

endmodule

//--- hw/fade_writer.sv
// ########################################
// fizzle fade that waits a few frames and then writes the fade colour
// to every framebuffer word once, in LFSR order
// ########################################
`timescale 1ns/1ps

module fade_writer (
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               frame,
    output fizzle_pkg::fb_wr_t fb_wr
);
    import fizzle_pkg::*;

    localparam int waitw       = $clog2(fade_wait + 2);  // counts the opening flag too
    localparam int ratew       = $clog2(fade_rate);
    localparam int lfsr_states = (1 << fb_addrw) - 1;  // nonzero states only

    logic [waitw-1:0]    cnt_wait;   // frame flags seen, saturating
    logic [ratew-1:0]    cnt_rate;
    logic [fb_addrw-1:0] lfsr;
    logic [fb_addrw-1:0] steps;      // LFSR steps taken
    logic [fb_addrw-1:0] lfsr_addr;
    logic waited;
    logic fading;
    logic step;
    logic in_range;

    always_comb begin
        waited    = (cnt_wait == waitw'(fade_wait + 1));  // first flag opens frame 0
        fading    = waited && (steps != fb_addrw'(lfsr_states));  // stops after full cycle
        step      = fading && (cnt_rate == ratew'(fade_rate - 1));
        lfsr_addr = lfsr - 1'b1;                      // states 1..255 -> 0..254
        in_range  = (lfsr_addr < fb_addrw'(fb_pixels));  // skip 192 and up
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cnt_wait <= '0;
            cnt_rate <= '0;
            steps    <= '0;
            lfsr     <= lfsr_seed;
        end else begin
            if (frame && !waited) cnt_wait <= cnt_wait + 1'b1;
            if (fading) cnt_rate <= step ? '0 : cnt_rate + 1'b1;
            if (step) begin
                // galois shift right with the taps folded back in
                lfsr  <= {1'b0, lfsr[fb_addrw-1:1]} ^ (lfsr[0] ? lfsr_taps : '0);
                steps <= steps + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        fb_wr.addr <= lfsr_addr;
        fb_wr.cidx <= fade_cidx;
        if (rst) fb_wr.we <= 1'b0;
        else     fb_wr.we <= step && in_range;  // single-cycle strobe
    end

    a_wr_range: assert property (@(posedge clk_sys) disable iff (rst)
        fb_wr.we |-> (fb_wr.addr < fb_addrw'(fb_pixels)));

    // zero would lock the LFSR up for good
    a_lfsr_live: assert property (@(posedge clk_sys) disable iff (rst)
        lfsr != '0);

endmodule

//--- hw/fb_ram.sv
// ########################################
// framebuffer of colour indices, preloaded from the image file
// one write port, one registered read port
// ########################################
`timescale 1ns/1ps

module fb_ram (
    input  logic                             clk_sys,
    input  fizzle_pkg::fb_wr_t               wr,
    input  logic [fizzle_pkg::fb_addrw-1:0]  rd_addr,
    output logic [fizzle_pkg::cidxw-1:0]     rd_cidx
);
    import fizzle_pkg::*;

    logic [cidxw-1:0] mem [fb_pixels];  // one index per fb pixel

    // 12 lines of 16 hex digits
    initial begin
        $readmemh(image_file, mem);
    end

    // same-cycle read returns old word
    // new word visible from the next cycle on
    always_ff @(posedge clk_sys) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.cidx;  // fade colour lands here
        end
        rd_cidx <= mem[rd_addr];      // 1 cycle read latency
    end

endmodule

//--- hw/scan_reader.sv
// ########################################
// line-buffered framebuffer scan, fetches each fb row into a
// two-row store and replays it scaled 2x2 one cycle behind the raster
// ########################################
`timescale 1ns/1ps

module scan_reader (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  fizzle_pkg::raster_t              raster,
    output logic [fizzle_pkg::fb_addrw-1:0]  rd_addr,
    input  logic [fizzle_pkg::cidxw-1:0]     rd_cidx,
    output logic [fizzle_pkg::cidxw-1:0]     lb_cidx,
    output fizzle_pkg::raster_t              raster_d
);
    import fizzle_pkg::*;

    logic [cidxw-1:0] lb [2 * fb_width];  // two rows, half picked by row parity

    logic signed [cordw-1:0] sy_next;   // screen line after this one
    logic [fb_yw-1:0]        row_next;  // fb row shown on it
    logic                    fetch_go;

    logic             fetch;  // burst in progress
    logic [fb_xw-1:0] fx;     // column being read
    logic             fsel;   // store half for this burst
    logic             lb_we;  // read data valid this cycle
    logic [fb_xw-1:0] lb_wx;  // column of that data

    logic [fb_yw-1:0] row_cur;  // fb row on screen now
    logic [fb_xw-1:0] rx;       // fb column under sx

    always_comb begin
        sy_next  = (raster.sy == cordw'(v_total - 1)) ? '0 : raster.sy + cordw'(1);
        row_next = fb_yw'(sy_next / fb_scale);
        // fetch only ahead of the first line of each fb row
        fetch_go = raster.line && (sy_next < cordw'(v_active)) && (sy_next % fb_scale == 0);
        row_cur  = fb_yw'(raster.sy / fb_scale);
        rx       = fb_xw'(raster.sx / fb_scale);  // wraps past the picture, blanked later
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            fetch <= 1'b0;
            lb_we <= 1'b0;
        end else begin
            lb_we <= fetch;  // ram answers one cycle later
            if (fetch_go) begin
                fetch <= 1'b1;
            end else if (fetch && fx == fb_xw'(fb_width - 1)) begin
                fetch <= 1'b0;  // 16 reads issued
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        lb_wx <= fx;
        if (fetch_go) begin
            fx      <= '0;
            rd_addr <= fb_addrw'(row_next * fb_width);  // row base
            fsel    <= row_next[0];
        end else if (fetch && fx != fb_xw'(fb_width - 1)) begin
            fx      <= fx + 1'b1;
            rd_addr <= rd_addr + 1'b1;  // stays inside the row
        end
    end

    // fill one half, replay the other
    always_ff @(posedge clk_sys) begin
        if (lb_we) lb[{fsel, lb_wx}] <= rd_cidx;
        lb_cidx <= lb[{row_cur[0], rx}];
    end

    // position copy lines up with lb_cidx
    always_ff @(posedge clk_sys) begin
        raster_d.sx <= raster.sx;
        raster_d.sy <= raster.sy;
        if (rst) begin
            raster_d.de    <= 1'b0;
            raster_d.frame <= 1'b0;
            raster_d.line  <= 1'b0;
        end else begin
            raster_d.de    <= raster.de;
            raster_d.frame <= raster.frame;
            raster_d.line  <= raster.line;
        end
    end

    // burst must be done within one line
    a_fetch_done: assert property (@(posedge clk_sys) disable iff (rst)
        raster.line |-> !fetch);

endmodule

//--- hw/pixel_painter.sv
// ########################################
// palette lookup and output stage, blanks outside the picture
// and widens 4-bit channels to 8 bits
// ########################################
`timescale 1ns/1ps

module pixel_painter (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  logic [fizzle_pkg::cidxw-1:0]  lb_cidx,
    input  fizzle_pkg::raster_t           raster_d,
    output fizzle_pkg::rgb24_t            pix,
    output fizzle_pkg::raster_t           pix_pos
);
    import fizzle_pkg::*;

    logic [colrw-1:0] pal [1 << cidxw];  // 16 entries of 0xRGB
    rgb12_t  colr;   // looked-up colour
    raster_t pos_p;  // position matching colr
    logic    paint;
    rgb24_t  wide;

    initial begin
        $readmemh(palette_file, pal);
    end

    // stage 1, palette lookup
    always_ff @(posedge clk_sys) begin
        colr     <= pal[lb_cidx];
        pos_p.sx <= raster_d.sx;
        pos_p.sy <= raster_d.sy;
        if (rst) begin
            pos_p.de    <= 1'b0;
            pos_p.frame <= 1'b0;
            pos_p.line  <= 1'b0;
        end else begin
            pos_p.de    <= raster_d.de;
            pos_p.frame <= raster_d.frame;
            pos_p.line  <= raster_d.line;
        end
    end

    always_comb begin
        paint = pos_p.de && !pos_p.sx[cordw-1] && !pos_p.sy[cordw-1]
            && (pos_p.sx < cordw'(fb_width * fb_scale))
            && (pos_p.sy < cordw'(fb_height * fb_scale));
        wide.r = {(8 / chanw){colr.r}};  // 0xA -> 0xAA
        wide.g = {(8 / chanw){colr.g}};
        wide.b = {(8 / chanw){colr.b}};
    end

    // stage 2, output register
    always_ff @(posedge clk_sys) begin
        pix        <= paint ? wide : '0;  // black in blanking
        pix_pos.sx <= pos_p.sx;
        pix_pos.sy <= pos_p.sy;
        if (rst) begin
            pix_pos.de    <= 1'b0;
            pix_pos.frame <= 1'b0;
            pix_pos.line  <= 1'b0;
        end else begin
            pix_pos.de    <= pos_p.de;
            pix_pos.frame <= pos_p.frame;
            pix_pos.line  <= pos_p.line;
        end
    end

    // blanking carried through both stages
    a_blank: assert property (@(posedge clk_sys) disable iff (rst)
        !raster_d.de |-> ##2 (pix == '0));

endmodule

//--- hw/fizzle_fb_top.sv
// ########################################
// fizzle framebuffer top, raster + fade + scan + paint
// pix and pix_pos trail the raster by 3 cycles
// ########################################
`timescale 1ns/1ps

module fizzle_fb_top (
    input  logic                clk_sys,
    input  logic                rst,
    output fizzle_pkg::rgb24_t  pix,
    output fizzle_pkg::raster_t pix_pos
);
    import fizzle_pkg::*;

    raster_t             raster;    // live position
    raster_t             raster_d;  // 1 cycle behind, with lb_cidx
    fb_wr_t              fb_wr;
    logic [fb_addrw-1:0] rd_addr;
    logic [cidxw-1:0]    rd_cidx;
    logic [cidxw-1:0]    lb_cidx;

    display_timing i_display_timing (
        .clk_sys (clk_sys),
        .rst     (rst),
        .raster  (raster)
    );

    // fade writer only needs the frame flag
    fade_writer i_fade_writer (
        .clk_sys (clk_sys),
        .rst     (rst),
        .frame   (raster.frame),
        .fb_wr   (fb_wr)
    );

    fb_ram i_fb_ram (
        .clk_sys (clk_sys),
        .wr      (fb_wr),
        .rd_addr (rd_addr),
        .rd_cidx (rd_cidx)
    );

    scan_reader i_scan_reader (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .raster   (raster),
        .rd_addr  (rd_addr),
        .rd_cidx  (rd_cidx),
        .lb_cidx  (lb_cidx),
        .raster_d (raster_d)
    );

    pixel_painter i_pixel_painter (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .lb_cidx  (lb_cidx),
        .raster_d (raster_d),
        .pix      (pix),
        .pix_pos  (pix_pos)
    );

endmodule

//--- include/fizzle_tb_model.svh
// ########################################
// reference model for the fizzle testbench, include inside the
// testbench module after importing fizzle_pkg
// ########################################
`ifndef FIZZLE_TB_MODEL_SVH
`define FIZZLE_TB_MODEL_SVH

typedef logic [cidxw-1:0]    image_t   [fb_pixels];
typedef logic [colrw-1:0]    palette_t [1 << cidxw];
typedef logic [fb_addrw-1:0] order_t   [fb_pixels];  // fade write order

function automatic void read_image(output image_t img);
    $readmemh(image_file, img);
endfunction

function automatic void load_palette(output palette_t pal);
    $readmemh(palette_file, pal);
endfunction

// one galois step with the RTL taps
function automatic logic [fb_addrw-1:0] lfsr_step(logic [fb_addrw-1:0] s);
    logic [fb_addrw-1:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ lfsr_taps;  // feedback bit folds into the taps
    return n;
endfunction

// addresses in fade order with out-of-range states skipped
function automatic void build_fade_order(output order_t order);
    logic [fb_addrw-1:0] s;
    logic [fb_addrw-1:0] a;
    int                  n;
    s = lfsr_seed;
    n = 0;
    for (int i = 0; i < (1 << fb_addrw) - 1; i++) begin
        a = s - 1'b1;
        if (a < fb_addrw'(fb_pixels)) begin
            order[n] = a;
            n++;
        end
        s = lfsr_step(s);
    end
endfunction

// each nibble doubled into a byte
function automatic rgb24_t widen_colour(rgb12_t c);
    rgb24_t w;
    w.r = {c.r, c.r};
    w.g = {c.g, c.g};
    w.b = {c.b, c.b};
    return w;
endfunction

// expected colour at a position or black outside de
function automatic rgb24_t expected_pixel(image_t img, palette_t pal, raster_t pos);
    rgb24_t c;
    int     idx;
    c = '0;
    if (pos.de) begin
        idx = (int'(pos.sy) / fb_scale) * fb_width + int'(pos.sx) / fb_scale;
        c   = widen_colour(pal[img[idx]]);
    end
    return c;
endfunction

// index whose colour matches pix or -1
function automatic int match_cidx(palette_t pal, rgb24_t pix);
    int found;
    found = -1;
    for (int i = (1 << cidxw) - 1; i >= 0; i--) begin
        if (widen_colour(pal[i]) == pix) found = i;  // lowest match wins
    end
    return found;
endfunction

`endif

//--- testbench/tb_fizzle_fb.sv
// ########################################
// testbench for the fizzle framebuffer that captures output frames and
// checks raster order, blanking, image colours and fade progress
// ########################################
`timescale 1ns/1ps

module tb_fizzle_fb;
    import fizzle_pkg::*;

    `include "fizzle_tb_model.svh"

    localparam int frame_cycles = h_total * v_total;
    localparam int done_frame   = fade_wait
        + (((1 << fb_addrw) - 1) * fade_rate + frame_cycles) / frame_cycles + 1;
    localparam int n_frames     = done_frame + 3;  // a few fully faded frames at the end

    logic    clk_sys;
    logic    rst;
    rgb24_t  pix;
    raster_t pix_pos;

    image_t   img;
    image_t   work_img;              // image with the first n_done addresses faded
    palette_t pal;
    order_t   order;
    int       pos_of [fb_pixels];    // place of each address in the fade order
    rgb24_t   cap [v_active][h_active];
    int       n_cur;                 // fade prefix seen so far
    int       n_done;
    int       seed;
    int       pix_errs;
    int       pos_errs;
    int       fade_errs;
    int       tmo_errs;

    fizzle_fb_top i_fizzle_fb_top (
        .clk_sys (clk_sys),
        .rst     (rst),
        .pix     (pix),
        .pix_pos (pix_pos)
    );

    always #4 clk_sys = ~clk_sys;  // 8 ns period

    initial begin
        clk_sys = 1'b0;
        rst     = 1'b1;
        repeat (3) @(posedge clk_sys);
        #1 rst = 1'b0;  // off the edge
    end

    // expected output position for raster step (x, y)
    function automatic raster_t ref_pos(input int x, input int y);
        raster_t p;
        p.sx    = cordw'(x);
        p.sy    = cordw'(y);
        p.de    = (x < h_active) && (y < v_active);
        p.frame = (x == 0) && (y == 0);
        p.line  = (x == 0);
        return p;
    endfunction

    task automatic check_rgb(input rgb24_t exp, input rgb24_t act, input int x, input int y);
        if (act !== exp) begin
            $display("[FAIL] pix at (%0d,%0d): expected %h, got %h", x, y, exp, act);
            pix_errs++;
        end
    endtask

    task automatic check_pos(input raster_t exp, input raster_t act);
        if (act !== exp) begin
            $display("[FAIL] pix_pos: expected %h, got %h", exp, act);
            pos_errs++;
        end
    endtask

    // blanking checked at once and active pixels kept for the frame check
    task automatic capture_pixel(input int x, input int y);
        raster_t p;
        p = ref_pos(x, y);
        check_pos(p, pix_pos);
        if (p.de) cap[y][x] = pix;
        else      check_rgb(expected_pixel(work_img, pal, p), pix, x, y);
    endtask

    // each fb row shows a prefix of the fade order that grows row by row
    task automatic analyze_frame(input int f, input bit full);
        int lo;
        int hi;
        int a;
        int c;
        for (int r = 0; r < fb_height; r++) begin
            lo = 0;
            hi = fb_pixels;
            for (int x = 0; x < fb_width; x++) begin
                a = r * fb_width + x;
                c = match_cidx(pal, cap[fb_scale * r][fb_scale * x]);
                if (c < 0) begin
                    $display("frame %0d: pixel of fb word %0d matches no palette colour", f, a);
                    pix_errs++;
                end else if (c == int'(fade_cidx)) begin
                    if (pos_of[a] + 1 > lo) lo = pos_of[a] + 1;  // faded so the prefix reaches it
                end else if (pos_of[a] < hi) begin
                    hi = pos_of[a];  // unfaded so the prefix ends before it
                end
            end
            if (lo > n_cur) n_cur = lo;
            if (n_cur > hi) begin
                $display("frame %0d row %0d: faded pixels are not a prefix of the fade order", f, r);
                fade_errs++;
            end
            while (n_done < n_cur) begin
                work_img[order[n_done]] = fade_cidx;
                n_done++;
            end
            if (full) begin
                for (int y = fb_scale * r; y < fb_scale * (r + 1); y++) begin
                    for (int x = 0; x < h_active; x++) begin
                        check_rgb(expected_pixel(work_img, pal, ref_pos(x, y)), cap[y][x], x, y);
                    end
                end
            end
        end
        if (f < fade_wait && n_cur != 0) begin
            $display("frame %0d: fade began before the wait frames were over", f);
            fade_errs++;
        end
        if (f >= done_frame && n_cur != fb_pixels) begin
            $display("frame %0d: fade incomplete, %0d of %0d words faded", f, n_cur, fb_pixels);
            fade_errs++;
        end
    endtask

    initial begin
        int  t;
        int  r;
        bit  full;
        seed      = 25487;
        pix_errs  = 0;
        pos_errs  = 0;
        fade_errs = 0;
        tmo_errs  = 0;
        read_image(img);
        load_palette(pal);
        build_fade_order(order);
        for (int i = 0; i < fb_pixels; i++) pos_of[order[i]] = i;
        work_img  = img;
        n_cur     = 0;
        n_done    = 0;

        // outputs sampled mid-cycle
        t = 0;
        @(negedge clk_sys);
        while (pix_pos.frame !== 1'b1 && t < 4 * frame_cycles) begin
            @(negedge clk_sys);
            t++;
        end

        if (pix_pos.frame !== 1'b1) begin
            $display("timeout: no frame flag seen on pix_pos after reset");
            tmo_errs++;
        end else begin
            for (int f = 0; f < n_frames; f++) begin
                r    = $random(seed);
                full = (f == 1) || (f == n_frames - 1) || r[0];  // random picks the rest
                for (int y = 0; y < v_total; y++) begin
                    for (int x = 0; x < h_total; x++) begin
                        capture_pixel(x, y);
                        @(negedge clk_sys);
                    end
                end
                if (f > 0) analyze_frame(f, full);  // frame 0 has no row 0 fetch
            end
        end

        $display("errors: pixel %0d position %0d fade %0d timeout %0d",
            pix_errs, pos_errs, fade_errs, tmo_errs);
        if (pix_errs + pos_errs + fade_errs + tmo_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- fizzle_fb_top.f
+incdir+include
hw/fizzle_pkg.sv
hw/display_timing.sv
hw/fade_writer.sv
hw/fb_ram.sv
hw/scan_reader.sv
hw/pixel_painter.sv
hw/fizzle_fb_top.sv
testbench/tb_fizzle_fb.sv

//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat fizzle_fb_top.f))
BIN  := obj_dir/Vtb_fizzle_fb

.PHONY: all run clean

all: run

$(BIN): fizzle_fb_top.f $(SRCS) include/fizzle_tb_model.svh
	verilator --binary --timing -Wno-fatal --top-module tb_fizzle_fb -f fizzle_fb_top.f

run: $(BIN) image.mem palette.mem
	-./$(BIN) > sim.log 2>&1
	cat sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- image.mem
// colour index per framebuffer pixel, 16 columns per line, rows 0 to 11
0 1 2 3 4 5 6 8 9 a b c d e f 0
2 3 4 5 6 8 9 a b c d e f 0 1 2
4 5 6 8 9 a b c d e f 0 1 2 3 4
6 8 9 a b c d e f 0 1 2 3 4 5 6
9 a b c d e f 0 1 2 3 4 5 6 8 9
b c d e f 0 1 2 3 4 5 6 8 9 a b
d e f 0 1 2 3 4 5 6 8 9 a b c d
f 0 1 2 3 4 5 6 8 9 a b c d e f
1 2 3 4 5 6 8 9 a b c d e f 0 1
3 4 5 6 8 9 a b c d e f 0 1 2 3
5 6 8 9 a b c d e f 0 1 2 3 4 5
8 9 a b c d e f 0 1 2 3 4 5 6 8

//--- palette.mem
// one colour per line as 0xRGB, palette index 0 to 15
000
00a
0a0
0aa
a00
a0a
a50
aaa
555
55f
5f5
5ff
f55
f5f
ff5
fff
